/* mmio_pkg.sv */
//**************************************************************************
// mmio interconnect shared definitions
// memory map, bus widths, host command codes and interrupt count for the
// apb port, scratch ram, interrupt controller and host-command register
//**************************************************************************
package mmio_pkg;

    // apb bus widths
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned STRB_W = DATA_W / 8;

    // target select nibble, address bits 31:28
    localparam int unsigned DEV_W = 4;
    localparam logic [DEV_W-1:0] DEV_HOST = 4'h4;
    localparam logic [DEV_W-1:0] DEV_PLIC = 4'h5;
    localparam logic [DEV_W-1:0] DEV_RAM  = 4'h8;

    // offset handed to the targets, address bits 7:0
    localparam int unsigned OFS_W = 8;

    // scratch ram geometry, word index from address bits 7:2
    localparam int unsigned RAM_WORDS = 64;
    localparam int unsigned RAM_AW    = 6;

    // interrupt sources, ids run from 1 to N_IRQ
    localparam int unsigned N_IRQ = 5;

    // interrupt controller register offsets
    localparam logic [OFS_W-1:0] PLIC_PENDING_OFS = 8'h00;
    localparam logic [OFS_W-1:0] PLIC_CLAIM_OFS   = 8'h04;

    // host commands, upper half of the written word
    localparam logic [15:0] CMD_PRINT_CHAR = 16'h0101;
    localparam logic [15:0] CMD_POWER_OFF  = 16'h0002;

endpackage

/* apb_slave_port.sv */
//**************************************************************************
// apb slave port
// decodes the target nibble, issues completion strobes to the targets and
// builds the read data and error response of each transfer
//**************************************************************************
module apb_slave_port (
    input  logic                            CLK,
    input  logic                            i_arst_n,
    input  logic                            i_psel,
    input  logic                            i_penable,
    input  logic                            i_pwrite,
    input  logic [mmio_pkg::ADDR_W-1:0]     i_paddr,
    input  logic [mmio_pkg::DATA_W-1:0]     i_pwdata,
    input  logic [mmio_pkg::STRB_W-1:0]     i_pstrb,
    input  logic [mmio_pkg::DATA_W-1:0]     i_ram_rdata,
    input  logic [mmio_pkg::DATA_W-1:0]     i_plic_rdata,
    input  logic [mmio_pkg::DATA_W-1:0]     i_host_rdata,
    input  logic                            i_host_stall,
    output logic                            o_pready,
    output logic [mmio_pkg::DATA_W-1:0]     o_prdata,
    output logic                            o_pslverr,
    output logic                            o_ram_sel,
    output logic                            o_plic_sel,
    output logic                            o_host_sel,
    output logic                            o_wr_en,
    output logic                            o_rd_en,
    output logic [mmio_pkg::OFS_W-1:0]      o_ofs,
    output logic [mmio_pkg::DATA_W-1:0]     o_wdata,
    output logic [mmio_pkg::STRB_W-1:0]     o_strb,
    output logic [mmio_pkg::RAM_AW-1:0]     o_ram_raddr
);

    logic [mmio_pkg::DEV_W-1:0]  dev;
    logic                        access;
    logic                        mapped;
    logic [mmio_pkg::DATA_W-1:0] rdata_sel;

    assign dev = i_paddr[mmio_pkg::ADDR_W-1 -: mmio_pkg::DEV_W];

    // selects are live in both setup and access phase
    assign o_ram_sel  = i_psel && (dev == mmio_pkg::DEV_RAM);
    assign o_plic_sel = i_psel && (dev == mmio_pkg::DEV_PLIC);
    assign o_host_sel = i_psel && (dev == mmio_pkg::DEV_HOST);
    assign mapped     = o_ram_sel || o_plic_sel || o_host_sel;

    // only a host write waits on a pending byte
    assign access   = i_psel && i_penable;
    assign o_pready = access && !(o_host_sel && i_pwrite && i_host_stall);
    assign o_wr_en  = o_pready && i_pwrite;
    assign o_rd_en  = o_pready && !i_pwrite;

    assign o_ofs       = i_paddr[mmio_pkg::OFS_W-1:0];
    assign o_wdata     = i_pwdata;
    assign o_strb      = i_pstrb;
    // ram read launched from the setup-phase address
    assign o_ram_raddr = i_paddr[mmio_pkg::RAM_AW+1:2];

    always_comb begin
        case (dev)
            mmio_pkg::DEV_RAM:  rdata_sel = i_ram_rdata;
            mmio_pkg::DEV_PLIC: rdata_sel = i_plic_rdata;
            mmio_pkg::DEV_HOST: rdata_sel = i_host_rdata;
            default:            rdata_sel = '0;
        endcase
    end

    // unmapped nibbles fall through to zero data
    assign o_prdata  = o_rd_en ? rdata_sel : '0;
    assign o_pslverr = o_pready && !mapped;

    a_penable_needs_psel: assert property (
        @(posedge CLK) disable iff (!i_arst_n)
        i_penable |-> i_psel
    ) else $error("apb: penable without psel");

    // master must hold the request while the access is stretched
    a_stretch_stable: assert property (
        @(posedge CLK) disable iff (!i_arst_n)
        (access && !o_pready) |=> $stable(i_paddr) && $stable(i_pwdata)
    ) else $error("apb: request changed during stretched access");

endmodule

/* scratch_ram.sv */
//**************************************************************************
// scratch ram
// 64-word memory with per-byte-lane writes and a registered read port
// addressed from the setup phase of the apb transfer
//**************************************************************************
module scratch_ram (
    input  logic                            CLK,
    input  logic                            i_sel,
    input  logic                            i_wr_en,
    input  logic [mmio_pkg::RAM_AW-1:0]     i_raddr,
    input  logic [mmio_pkg::OFS_W-1:0]      i_ofs,
    input  logic [mmio_pkg::DATA_W-1:0]     i_wdata,
    input  logic [mmio_pkg::STRB_W-1:0]     i_strb,
    output logic [mmio_pkg::DATA_W-1:0]     o_rdata
);

    logic [mmio_pkg::DATA_W-1:0] mem [mmio_pkg::RAM_WORDS];
    logic [mmio_pkg::RAM_AW-1:0] widx;
    logic                        we;

    assign widx = i_ofs[mmio_pkg::RAM_AW+1:2];
    assign we   = i_sel && i_wr_en;

    // byte lanes written under the strobe
    always_ff @(posedge CLK) begin
        if (we) begin
            for (int b = 0; b < mmio_pkg::STRB_W; b++) begin
                if (i_strb[b]) begin
                    mem[widx][8*b +: 8] <= i_wdata[8*b +: 8];
                end
            end
        end
    end

    // read every cycle, lands in the access phase
    always_ff @(posedge CLK) begin
        o_rdata <= mem[i_raddr];
    end

    // a ram write completes only after a setup phase aimed at the ram
    a_write_after_setup: assert property (
        @(posedge CLK)
        we |-> $past(i_sel)
    ) else $error("ram: write strobe without prior select");

endmodule

/* irq_controller.sv */
//**************************************************************************
// interrupt controller
// pending and served state per source, claim by read and completion by
// write, external interrupt raised while any source is claimable
//**************************************************************************
module irq_controller (
    input  logic                            CLK,
    input  logic                            i_arst_n,
    input  logic [mmio_pkg::N_IRQ-1:0]      i_irq_src,
    input  logic                            i_sel,
    input  logic                            i_wr_en,
    input  logic                            i_rd_en,
    input  logic [mmio_pkg::OFS_W-1:0]      i_ofs,
    input  logic [mmio_pkg::DATA_W-1:0]     i_wdata,
    output logic [mmio_pkg::DATA_W-1:0]     o_rdata,
    output logic                            o_ext_irq
);

    logic [mmio_pkg::N_IRQ-1:0]  pending;
    logic [mmio_pkg::N_IRQ-1:0]  served;
    logic [mmio_pkg::N_IRQ-1:0]  claimable;
    logic [mmio_pkg::N_IRQ-1:0]  claim_mask;
    logic [mmio_pkg::N_IRQ-1:0]  done_mask;
    logic [mmio_pkg::DATA_W-1:0] claim_id;
    logic                        claim_rd;
    logic                        complete_wr;

    assign claimable  = pending & ~served;
    // isolate lowest set bit
    assign claim_mask = claimable & (~claimable + 1'b1);
    assign o_ext_irq  = |claimable;

    // id is index plus one, zero when nothing to claim
    always_comb begin
        claim_id  = '0;
        done_mask = '0;
        for (int i = 0; i < mmio_pkg::N_IRQ; i++) begin
            if (claim_mask[i]) begin
                claim_id = i + 1;
            end
            if (i_wdata == i + 1) begin
                done_mask[i] = 1'b1;
            end
        end
    end

    assign claim_rd    = i_sel && i_rd_en && (i_ofs == mmio_pkg::PLIC_CLAIM_OFS);
    assign complete_wr = i_sel && i_wr_en && (i_ofs == mmio_pkg::PLIC_CLAIM_OFS);

    always_comb begin
        case (i_ofs)
            mmio_pkg::PLIC_PENDING_OFS: o_rdata = {{(mmio_pkg::DATA_W-mmio_pkg::N_IRQ){1'b0}},
                                                   pending};
            mmio_pkg::PLIC_CLAIM_OFS:   o_rdata = claim_id;
            default:                    o_rdata = '0;
        endcase
    end

    // pulses on served sources are dropped until completion
    always_ff @(posedge CLK or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pending <= '0;
            served  <= '0;
        end else begin
            if (claim_rd) begin
                pending <= (pending | (i_irq_src & ~served)) & ~claim_mask;
                served  <= served | claim_mask;
            end else begin
                pending <= pending | (i_irq_src & ~served);
                if (complete_wr) begin
                    served <= served & ~done_mask;
                end
            end
        end
    end

    a_served_from_claimable: assert property (
        @(posedge CLK) disable iff (!i_arst_n)
        ((served & ~$past(served)) & ~$past(claimable)) == '0
    ) else $error("plic: served bit set on a source that was not claimable");

endmodule

/* host_command.sv */
//**************************************************************************
// host-command register
// print commands feed a byte stream with ready back-pressure and a
// power-off command raises a sticky finish flag
//**************************************************************************
module host_command (
    input  logic                            CLK,
    input  logic                            i_arst_n,
    input  logic                            i_sel,
    input  logic                            i_wr_en,
    input  logic [mmio_pkg::DATA_W-1:0]     i_wdata,
    input  logic                            i_char_ready,
    output logic [mmio_pkg::DATA_W-1:0]     o_rdata,
    output logic                            o_stall,
    output logic                            o_char_valid,
    output logic [7:0]                      o_char_data,
    output logic                            o_finish
);

    logic        wr;
    logic [15:0] cmd;
    logic        print_wr;
    logic        power_wr;

    assign wr       = i_sel && i_wr_en;
    assign cmd      = i_wdata[mmio_pkg::DATA_W-1 -: 16];
    assign print_wr = wr && (cmd == mmio_pkg::CMD_PRINT_CHAR);
    assign power_wr = wr && (cmd == mmio_pkg::CMD_POWER_OFF);

    // writes are held off by the port while a byte waits
    assign o_stall = o_char_valid;
    assign o_rdata = {{(mmio_pkg::DATA_W-1){1'b0}}, o_char_valid};

    always_ff @(posedge CLK or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_char_valid <= 1'b0;
            o_finish     <= 1'b0;
        end else begin
            if (print_wr) begin
                o_char_valid <= 1'b1;
            end else if (o_char_valid && i_char_ready) begin
                o_char_valid <= 1'b0;
            end
            // sticky until reset
            if (power_wr) begin
                o_finish <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (print_wr) begin
            o_char_data <= i_wdata[7:0];
        end
    end

    a_char_hold: assert property (
        @(posedge CLK) disable iff (!i_arst_n)
        (o_char_valid && !i_char_ready) |=> o_char_valid && $stable(o_char_data)
    ) else $error("host: byte dropped or changed before acceptance");

endmodule

/* mmio_interconnect.sv */
//**************************************************************************
// mmio interconnect top
// apb slave port routing transfers to the scratch ram, the interrupt
// controller and the host-command register
//**************************************************************************
module mmio_interconnect (
    input  logic                            CLK,
    input  logic                            i_arst_n,
    input  logic                            i_psel,
    input  logic                            i_penable,
    input  logic                            i_pwrite,
    input  logic [mmio_pkg::ADDR_W-1:0]     i_paddr,
    input  logic [mmio_pkg::DATA_W-1:0]     i_pwdata,
    input  logic [mmio_pkg::STRB_W-1:0]     i_pstrb,
    output logic                            o_pready,
    output logic [mmio_pkg::DATA_W-1:0]     o_prdata,
    output logic                            o_pslverr,
    input  logic [mmio_pkg::N_IRQ-1:0]      i_irq_src,
    output logic                            o_ext_irq,
    output logic                            o_char_valid,
    output logic [7:0]                      o_char_data,
    input  logic                            i_char_ready,
    output logic                            o_finish
);

    logic                        ram_sel;
    logic                        plic_sel;
    logic                        host_sel;
    logic                        wr_en;
    logic                        rd_en;
    logic [mmio_pkg::OFS_W-1:0]  ofs;
    logic [mmio_pkg::DATA_W-1:0] wdata;
    logic [mmio_pkg::STRB_W-1:0] strb;
    logic [mmio_pkg::RAM_AW-1:0] ram_raddr;
    logic [mmio_pkg::DATA_W-1:0] ram_rdata;
    logic [mmio_pkg::DATA_W-1:0] plic_rdata;
    logic [mmio_pkg::DATA_W-1:0] host_rdata;
    logic                        host_stall;

    apb_slave_port u_port (
        .CLK          (CLK),          .i_arst_n     (i_arst_n),
        .i_psel       (i_psel),       .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),     .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),     .i_pstrb      (i_pstrb),
        .i_ram_rdata  (ram_rdata),    .i_plic_rdata (plic_rdata),
        .i_host_rdata (host_rdata),   .i_host_stall (host_stall),
        .o_pready     (o_pready),     .o_prdata     (o_prdata),
        .o_pslverr    (o_pslverr),    .o_ram_sel    (ram_sel),
        .o_plic_sel   (plic_sel),     .o_host_sel   (host_sel),
        .o_wr_en      (wr_en),        .o_rd_en      (rd_en),
        .o_ofs        (ofs),          .o_wdata      (wdata),
        .o_strb       (strb),         .o_ram_raddr  (ram_raddr)
    );

    scratch_ram u_ram (
        .CLK     (CLK),      .i_sel   (ram_sel),
        .i_wr_en (wr_en),    .i_raddr (ram_raddr),
        .i_ofs   (ofs),      .i_wdata (wdata),
        .i_strb  (strb),     .o_rdata (ram_rdata)
    );

    irq_controller u_plic (
        .CLK       (CLK),        .i_arst_n  (i_arst_n),
        .i_irq_src (i_irq_src),  .i_sel     (plic_sel),
        .i_wr_en   (wr_en),      .i_rd_en   (rd_en),
        .i_ofs     (ofs),        .i_wdata   (wdata),
        .o_rdata   (plic_rdata), .o_ext_irq (o_ext_irq)
    );

    host_command u_host (
        .CLK          (CLK),          .i_arst_n     (i_arst_n),
        .i_sel        (host_sel),     .i_wr_en      (wr_en),
        .i_wdata      (wdata),        .i_char_ready (i_char_ready),
        .o_rdata      (host_rdata),   .o_stall      (host_stall),
        .o_char_valid (o_char_valid), .o_char_data  (o_char_data),
        .o_finish     (o_finish)
    );

endmodule

/* tb_mmio_interconnect.sv */
//**************************************************************************
// mmio interconnect testbench
// table-driven apb master covering ram byte lanes, unmapped errors,
// interrupt claim and completion, printed bytes and power off
//**************************************************************************
module tb_mmio_interconnect;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int OP_WR   = 0;
    localparam int OP_RD   = 1;
    localparam int OP_IRQ  = 2;
    localparam int OP_WAIT = 3;
    // no check on this column
    localparam int NC      = 2;

    typedef struct {
        int          op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic [31:0] exp_rd;
        logic        exp_err;
        int          hold;
        int          exp_irq;
        int          exp_fin;
    } row_t;

    logic        CLK;
    logic        i_arst_n;
    logic        i_psel;
    logic        i_penable;
    logic        i_pwrite;
    logic [31:0] i_paddr;
    logic [31:0] i_pwdata;
    logic [3:0]  i_pstrb;
    logic        o_pready;
    logic [31:0] o_prdata;
    logic        o_pslverr;
    logic [4:0]  i_irq_src;
    logic        o_ext_irq;
    logic        o_char_valid;
    logic [7:0]  o_char_data;
    logic        i_char_ready;
    logic        o_finish;

    row_t        rows[$];
    logic [7:0]  exp_bytes[$];
    int          errors;
    int          checks;
    int          cycles;
    int          limit;
    int          release_at;
    int          n_print_done;
    int          n_accepted;

    mmio_interconnect DUT (
        .CLK          (CLK),          .i_arst_n     (i_arst_n),
        .i_psel       (i_psel),       .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),     .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),     .i_pstrb      (i_pstrb),
        .o_pready     (o_pready),     .o_prdata     (o_prdata),
        .o_pslverr    (o_pslverr),    .i_irq_src    (i_irq_src),
        .o_ext_irq    (o_ext_irq),    .o_char_valid (o_char_valid),
        .o_char_data  (o_char_data),  .i_char_ready (i_char_ready),
        .o_finish     (o_finish)
    );

    always #10 CLK = ~CLK;

    // consumer back-pressure ends once the hold window has run out
    always @(negedge CLK) begin
        if (cycles >= release_at) begin
            i_char_ready = 1'b1;
        end
    end

    always @(posedge CLK) begin
        cycles++;
        if (limit != 0 && cycles > limit) begin
            $display("timeout: run exceeded %0d cycles", limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    // bytes seen on accepting edges, in write order
    always @(posedge CLK) begin
        if (i_arst_n && o_char_valid && i_char_ready) begin
            n_accepted++;
            if (exp_bytes.size() == 0) begin
                errors++;
                $display("unexpected byte %h on the output stream at %0t", o_char_data, $time);
            end else begin
                compare("o_char_data", exp_bytes.pop_front(), o_char_data);
            end
        end
    end

    task automatic add_row(input int op, input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] strb, input logic [31:0] exp_rd,
                           input logic exp_err, input int hold, input int exp_irq,
                           input int exp_fin);
        row_t r;
        r = '{op, addr, wdata, strb, exp_rd, exp_err, hold, exp_irq, exp_fin};
        rows.push_back(r);
    endtask

    task automatic build_table();
        // ram lanes, partial strobes merge into the old word
        add_row(OP_WR,   32'h8000_0000, 32'h1122_3344, 4'hF, 0, 0, 0, 0, 0);
        add_row(OP_WR,   32'h8000_0004, 32'hAABB_CCDD, 4'hF, 0, 0, 0, NC, NC);
        add_row(OP_WR,   32'h8000_0000, 32'h9988_7766, 4'h5, 0, 0, 0, NC, NC);
        add_row(OP_WR,   32'h8000_0004, 32'h5544_3322, 4'h8, 0, 0, 0, NC, NC);
        add_row(OP_RD,   32'h8000_0000, 0, 0, 32'h1188_3366, 0, 0, NC, NC);
        add_row(OP_RD,   32'h8000_0004, 0, 0, 32'h55BB_CCDD, 0, 0, NC, NC);
        add_row(OP_WR,   32'h8000_00FC, 32'h0BAD_F00D, 4'hF, 0, 0, 0, NC, NC);
        add_row(OP_RD,   32'h8000_00FC, 0, 0, 32'h0BAD_F00D, 0, 0, NC, NC);
        // unmapped nibbles
        add_row(OP_RD,   32'h0000_0010, 0, 0, 0, 1, 0, NC, NC);
        add_row(OP_WR,   32'h9000_0000, 32'hFFFF_FFFF, 4'hF, 0, 1, 0, NC, NC);
        add_row(OP_RD,   32'h9000_0004, 0, 0, 0, 1, 0, NC, NC);
        // sources 1 and 3 raised, claimed lowest first
        add_row(OP_IRQ,  0, 32'h0A, 0, 0, 0, 0, 1, NC);
        add_row(OP_RD,   32'h5000_0000, 0, 0, 32'h0A, 0, 0, 1, NC);
        add_row(OP_RD,   32'h5000_0004, 0, 0, 2, 0, 0, 1, NC);
        add_row(OP_RD,   32'h5000_0000, 0, 0, 32'h08, 0, 0, 1, NC);
        add_row(OP_RD,   32'h5000_0004, 0, 0, 4, 0, 0, 0, NC);
        add_row(OP_RD,   32'h5000_0004, 0, 0, 0, 0, 0, 0, NC);
        // pulse on a served source is dropped
        add_row(OP_IRQ,  0, 32'h02, 0, 0, 0, 0, 0, NC);
        add_row(OP_RD,   32'h5000_0000, 0, 0, 0, 0, 0, 0, NC);
        add_row(OP_WR,   32'h5000_0004, 2, 4'hF, 0, 0, 0, 0, NC);
        add_row(OP_IRQ,  0, 32'h02, 0, 0, 0, 0, 1, NC);
        add_row(OP_RD,   32'h5000_0004, 0, 0, 2, 0, 0, 0, NC);
        add_row(OP_WR,   32'h5000_0004, 2, 4'hF, 0, 0, 0, 0, NC);
        add_row(OP_WR,   32'h5000_0004, 4, 4'hF, 0, 0, 0, 0, NC);
        // printed bytes, second print stalls behind the first
        add_row(OP_WR,   32'h4000_0000, 32'h0101_0041, 4'hF, 0, 0, 3, NC, NC);
        add_row(OP_WR,   32'h4000_0000, 32'h0101_0042, 4'hF, 0, 0, 0, NC, NC);
        add_row(OP_WR,   32'h4000_0000, 32'h0007_0043, 4'hF, 0, 0, 0, NC, NC);
        add_row(OP_WAIT, 0, 2, 0, 0, 0, 0, NC, NC);
        add_row(OP_RD,   32'h4000_0000, 0, 0, 0, 0, 0, NC, NC);
        add_row(OP_WR,   32'h4000_0000, 32'h0101_0043, 4'hF, 0, 0, 6, NC, NC);
        add_row(OP_RD,   32'h4000_0000, 0, 0, 1, 0, 0, NC, NC);
        add_row(OP_WAIT, 0, 8, 0, 0, 0, 0, NC, 0);
        // power off is sticky
        add_row(OP_WR,   32'h4000_0000, 32'h0002_0000, 4'hF, 0, 0, 0, NC, 1);
        add_row(OP_WAIT, 0, 2, 0, 0, 0, 0, NC, 1);
    endtask

    task automatic run_transfer(input row_t r);
        logic is_print;
        logic is_host_wr;
        int   waits;
        is_host_wr = (r.op == OP_WR) && (r.addr[31:28] == 4'h4);
        is_print   = is_host_wr && (r.wdata[31:16] == 16'h0101);
        waits      = 0;
        if (r.hold > 0) begin
            i_char_ready = 1'b0;
            release_at   = cycles + r.hold;
        end
        if (is_print) begin
            exp_bytes.push_back(r.wdata[7:0]);
        end
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = (r.op == OP_WR);
        i_paddr   = r.addr;
        i_pwdata  = r.wdata;
        i_pstrb   = r.strb;
        @(negedge CLK);
        i_penable = 1'b1;
        @(posedge CLK);
        while (!o_pready) begin
            waits++;
            @(posedge CLK);
        end
        // only a host write may wait on a pending byte
        if (!is_host_wr && waits != 0) begin
            errors++;
            $display("transfer at %h stretched by %0d cycles at %0t", r.addr, waits, $time);
        end
        if (r.op == OP_RD) begin
            compare("o_prdata", r.exp_rd, o_prdata);
        end
        compare("o_pslverr", r.exp_err, o_pslverr);
        // an earlier byte must be gone before a new print completes
        if (is_print) begin
            if (n_accepted != n_print_done) begin
                errors++;
                $display("print write completed at %0t while a byte was still waiting", $time);
            end
            n_print_done++;
        end
        @(negedge CLK);
        i_psel    = 1'b0;
        i_penable = 1'b0;
    endtask

    initial begin
        CLK          = 1'b0;
        i_arst_n     = 1'b0;
        i_psel       = 1'b0;
        i_penable    = 1'b0;
        i_pwrite     = 1'b0;
        i_paddr      = '0;
        i_pwdata     = '0;
        i_pstrb      = '0;
        i_irq_src    = '0;
        i_char_ready = 1'b1;
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        release_at   = 0;
        n_print_done = 0;
        n_accepted   = 0;
        build_table();
        limit = 20 * rows.size() + 100;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        i_arst_n = 1'b1;
        foreach (rows[i]) begin
            case (rows[i].op)
                OP_WR, OP_RD: run_transfer(rows[i]);
                OP_IRQ: begin
                    i_irq_src = rows[i].wdata[4:0];
                    @(negedge CLK);
                    i_irq_src = '0;
                end
                default: repeat (rows[i].wdata) @(negedge CLK);
            endcase
            if (rows[i].exp_irq != NC) begin
                compare("o_ext_irq", rows[i].exp_irq, o_ext_irq);
            end
            if (rows[i].exp_fin != NC) begin
                compare("o_finish", rows[i].exp_fin, o_finish);
            end
        end
        if (exp_bytes.size() != 0) begin
            errors++;
            $display("%0d printed bytes never appeared on the output stream", exp_bytes.size());
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
mmio_pkg.sv
apb_slave_port.sv
scratch_ram.sv
irq_controller.sv
host_command.sv
mmio_interconnect.sv
tb_mmio_interconnect.sv

/* Bender.yml */
package:
  name: mmio_interconnect

sources:
  - mmio_pkg.sv
  - apb_slave_port.sv
  - scratch_ram.sv
  - irq_controller.sv
  - host_command.sv
  - mmio_interconnect.sv
  - target: test
    files:
      - tb_mmio_interconnect.sv
